// File: hw/rv32_exec_pkg.sv
package rv32_exec_pkg;

  // data word, also used for pc, addresses and immediates
  typedef logic [31:0] word_t;
  // register index
  typedef logic [4:0] reg_addr_t;

  // major opcodes of the RV32I base set
  typedef enum logic [6:0] {
    op_lui      = 7'b0110111,
    op_auipc    = 7'b0010111,
    op_jal      = 7'b1101111,
    op_jalr     = 7'b1100111,
    op_branch   = 7'b1100011,
    op_load     = 7'b0000011,
    op_store    = 7'b0100011,
    op_imm      = 7'b0010011,
    op_reg      = 7'b0110011,
    op_misc_mem = 7'b0001111,
    op_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  // encoded as funct3, which loads and stores share
  typedef enum logic [2:0] {
    lt_lb   = 3'b000,
    lt_lh   = 3'b001,
    lt_lw   = 3'b010,
    lt_lbu  = 3'b100,
    lt_lhu  = 3'b101,
    lt_none = 3'b111
  } load_type_e;

  // encoded as the branch funct3
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_type_e;

  typedef enum logic [1:0] {w_sel_load, w_sel_pc4, w_sel_imm_u, w_sel_alu} w_sel_e;

  typedef enum logic {a_sel_rs1, a_sel_pc} alu_a_sel_e;

  typedef enum logic [1:0] {b_sel_rs2, b_sel_imm_i, b_sel_imm_s, b_sel_imm_u} alu_b_sel_e;

endpackage

// File: hw/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  rv32_exec_pkg::word_t        instr,
  output rv32_exec_pkg::reg_addr_t    rs1,
  output rv32_exec_pkg::reg_addr_t    rs2,
  output rv32_exec_pkg::reg_addr_t    rd,
  output rv32_exec_pkg::word_t        imm_i,
  output rv32_exec_pkg::word_t        imm_s,
  output rv32_exec_pkg::word_t        imm_sb,
  output rv32_exec_pkg::word_t        imm_uj,
  output rv32_exec_pkg::word_t        imm_u,
  output rv32_exec_pkg::alu_op_e      alu_op,
  output rv32_exec_pkg::alu_a_sel_e   alu_a_sel,
  output rv32_exec_pkg::alu_b_sel_e   alu_b_sel,
  output rv32_exec_pkg::w_sel_e       w_sel,
  output logic                        reg_wen,
  output logic                        dren,
  output logic                        dwen,
  output rv32_exec_pkg::load_type_e   load_type,
  output logic                        branch,
  output rv32_exec_pkg::branch_type_e branch_type,
  output logic                        jump,
  output logic                        j_sel,
  output logic                        halt,
  output logic                        illegal_insn
);

  rv32_exec_pkg::opcode_e opcode;
  rv32_exec_pkg::alu_op_e arith_op;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic                   bubble;
  logic                   illegal;

  assign opcode = rv32_exec_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  // all-zero word is what fetch sends when it has nothing
  assign bubble = (instr == '0);

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];

  // immediate formats, all sign extended from bit 31
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_sb = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_uj = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u  = {instr[31:12], 12'b0};

  // alu op for the OP and OP-IMM groups
  // sub only exists in register form, srai shares funct7 bit 5 with sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == rv32_exec_pkg::op_reg && funct7[5]) ?
                          rv32_exec_pkg::alu_sub : rv32_exec_pkg::alu_add;
      3'b001:  arith_op = rv32_exec_pkg::alu_sll;
      3'b010:  arith_op = rv32_exec_pkg::alu_slt;
      3'b011:  arith_op = rv32_exec_pkg::alu_sltu;
      3'b100:  arith_op = rv32_exec_pkg::alu_xor;
      3'b101:  arith_op = funct7[5] ? rv32_exec_pkg::alu_sra : rv32_exec_pkg::alu_srl;
      3'b110:  arith_op = rv32_exec_pkg::alu_or;
      default: arith_op = rv32_exec_pkg::alu_and;
    endcase
  end

  always_comb begin
    // defaults describe a no-op that adds rs1 and rs2
    alu_op      = rv32_exec_pkg::alu_add;
    alu_a_sel   = rv32_exec_pkg::a_sel_rs1;
    alu_b_sel   = rv32_exec_pkg::b_sel_rs2;
    w_sel       = rv32_exec_pkg::w_sel_alu;
    reg_wen     = 1'b0;
    dren        = 1'b0;
    dwen        = 1'b0;
    load_type   = rv32_exec_pkg::lt_none;
    branch      = 1'b0;
    branch_type = rv32_exec_pkg::br_beq;
    jump        = 1'b0;
    j_sel       = 1'b0;
    halt        = 1'b0;
    illegal     = 1'b0;
    case (opcode)
      rv32_exec_pkg::op_lui: begin
        reg_wen = 1'b1;
        w_sel   = rv32_exec_pkg::w_sel_imm_u;
      end
      rv32_exec_pkg::op_auipc: begin
        reg_wen   = 1'b1;
        alu_a_sel = rv32_exec_pkg::a_sel_pc;
        alu_b_sel = rv32_exec_pkg::b_sel_imm_u;
      end
      rv32_exec_pkg::op_jal: begin
        reg_wen = 1'b1;
        w_sel   = rv32_exec_pkg::w_sel_pc4;
        jump    = 1'b1;
        j_sel   = 1'b1;
      end
      rv32_exec_pkg::op_jalr: begin
        reg_wen = 1'b1;
        w_sel   = rv32_exec_pkg::w_sel_pc4;
        jump    = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      rv32_exec_pkg::op_branch: begin
        branch      = 1'b1;
        branch_type = rv32_exec_pkg::branch_type_e'(funct3);
        // funct3 010 and 011 are unassigned
        illegal     = (funct3[2:1] == 2'b01);
      end
      rv32_exec_pkg::op_load: begin
        reg_wen   = 1'b1;
        dren      = 1'b1;
        w_sel     = rv32_exec_pkg::w_sel_load;
        alu_b_sel = rv32_exec_pkg::b_sel_imm_i;
        load_type = rv32_exec_pkg::load_type_e'(funct3);
        illegal   = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv32_exec_pkg::op_store: begin
        dwen      = 1'b1;
        alu_b_sel = rv32_exec_pkg::b_sel_imm_s;
        load_type = rv32_exec_pkg::load_type_e'(funct3);
        // only sb, sh and sw exist
        illegal   = funct3[2] || (funct3[1:0] == 2'b11);
      end
      rv32_exec_pkg::op_imm: begin
        reg_wen   = 1'b1;
        alu_b_sel = rv32_exec_pkg::b_sel_imm_i;
        alu_op    = arith_op;
        // shift immediates carry funct7 in the upper imm bits
        if (funct3 == 3'b001)
          illegal = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      rv32_exec_pkg::op_reg: begin
        reg_wen = 1'b1;
        alu_op  = arith_op;
        illegal = (funct7 != 7'b0000000) &&
                  !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      rv32_exec_pkg::op_misc_mem: begin
        // fence and fence.i behave as no-ops here
        illegal = (funct3[2:1] != 2'b00);
      end
      rv32_exec_pkg::op_system: begin
        // ecall and ebreak differ only in bit 20, csr forms are not supported
        if (instr[31:21] == '0 && instr[19:7] == '0)
          halt = 1'b1;
        else
          illegal = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
    // nothing may leave decode for an illegal word or a bubble
    if (illegal || bubble) begin
      reg_wen   = 1'b0;
      dren      = 1'b0;
      dwen      = 1'b0;
      branch    = 1'b0;
      jump      = 1'b0;
      halt      = 1'b0;
      load_type = rv32_exec_pkg::lt_none;
    end
  end

  assign illegal_insn = illegal & ~bubble;

endmodule

// File: hw/rv32i_reg_file.sv
`timescale 1ns/1ps

module rv32i_reg_file (
  input  logic                     CLK,
  input  logic                     rst,
  input  rv32_exec_pkg::reg_addr_t rs1,
  input  rv32_exec_pkg::reg_addr_t rs2,
  input  rv32_exec_pkg::reg_addr_t rd,
  input  logic                     wen,
  input  rv32_exec_pkg::word_t     w_data,
  output rv32_exec_pkg::word_t     rs1_data,
  output rv32_exec_pkg::word_t     rs2_data
);

  // x0 has no storage
  rv32_exec_pkg::word_t regs [1:31];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && rd != '0) begin
      regs[rd] <= w_data;
    end
  end

  // reads see the old value during a write in the same cycle
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
  input  rv32_exec_pkg::alu_op_e aluop,
  input  rv32_exec_pkg::word_t   port_a,
  input  rv32_exec_pkg::word_t   port_b,
  output rv32_exec_pkg::word_t   port_out
);

  // shift amount is the low five bits of operand b
  logic [4:0] shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    case (aluop)
      rv32_exec_pkg::alu_add:  port_out = port_a + port_b;
      rv32_exec_pkg::alu_sub:  port_out = port_a - port_b;
      rv32_exec_pkg::alu_sll:  port_out = port_a << shamt;
      // set on less than, signed then unsigned
      rv32_exec_pkg::alu_slt:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      rv32_exec_pkg::alu_sltu: port_out = {31'b0, port_a < port_b};
      rv32_exec_pkg::alu_xor:  port_out = port_a ^ port_b;
      rv32_exec_pkg::alu_srl:  port_out = port_a >> shamt;
      // arithmetic shift keeps the sign bit
      rv32_exec_pkg::alu_sra:  port_out = $signed(port_a) >>> shamt;
      rv32_exec_pkg::alu_or:   port_out = port_a | port_b;
      rv32_exec_pkg::alu_and:  port_out = port_a & port_b;
      default:                 port_out = '0;
    endcase
  end

endmodule

// File: hw/branch_res.sv
`timescale 1ns/1ps

module branch_res (
  input  rv32_exec_pkg::word_t        rs1_data,
  input  rv32_exec_pkg::word_t        rs2_data,
  input  rv32_exec_pkg::word_t        pc,
  input  rv32_exec_pkg::word_t        imm_sb,
  input  rv32_exec_pkg::branch_type_e branch_type,
  output logic                        branch_taken,
  output rv32_exec_pkg::word_t        branch_addr
);

  logic eq;
  logic lt_s;
  logic lt_u;

  // one comparator set shared by all six conditions
  assign eq   = (rs1_data == rs2_data);
  assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
  assign lt_u = (rs1_data < rs2_data);

  always_comb begin
    case (branch_type)
      rv32_exec_pkg::br_beq:  branch_taken = eq;
      rv32_exec_pkg::br_bne:  branch_taken = ~eq;
      rv32_exec_pkg::br_blt:  branch_taken = lt_s;
      rv32_exec_pkg::br_bge:  branch_taken = ~lt_s;
      rv32_exec_pkg::br_bltu: branch_taken = lt_u;
      rv32_exec_pkg::br_bgeu: branch_taken = ~lt_u;
      default:                branch_taken = 1'b0;
    endcase
  end

  // target is pc relative, the immediate already has bit 0 clear
  assign branch_addr = pc + imm_sb;

endmodule

// File: hw/dmem_align.sv
`timescale 1ns/1ps

module dmem_align (
  input  rv32_exec_pkg::load_type_e load_type,
  input  logic                      dren,
  input  logic                      dwen,
  input  logic [1:0]                addr_low,
  input  rv32_exec_pkg::word_t      store_data,
  input  rv32_exec_pkg::word_t      rdata,
  output logic [3:0]                byte_en,
  output logic                      mal_addr,
  output rv32_exec_pkg::word_t      wdata,
  output rv32_exec_pkg::word_t      load_data
);

  logic       access;
  logic       is_byte;
  logic       is_half;
  logic       is_word;
  logic [7:0] byte_lane;
  logic [15:0] half_lane;

  assign access  = dren | dwen;
  // unsigned forms only matter for loads, the lanes are the same
  assign is_byte = (load_type == rv32_exec_pkg::lt_lb) || (load_type == rv32_exec_pkg::lt_lbu);
  assign is_half = (load_type == rv32_exec_pkg::lt_lh) || (load_type == rv32_exec_pkg::lt_lhu);
  assign is_word = (load_type == rv32_exec_pkg::lt_lw);

  // word needs offset 0, half needs an even offset
  assign mal_addr = access && ((is_word && addr_low != 2'b00) || (is_half && addr_low[0]));

  // lane enables, cleared for misaligned or absent accesses
  always_comb begin
    byte_en = 4'b0000;
    if (access && !mal_addr) begin
      if (is_byte)
        byte_en = 4'b0001 << addr_low;
      else if (is_half)
        byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
      else if (is_word)
        byte_en = 4'b1111;
    end
  end

  // store data copied to every lane so byte_en picks the right one
  always_comb begin
    if (is_byte)
      wdata = {4{store_data[7:0]}};
    else if (is_half)
      wdata = {2{store_data[15:0]}};
    else
      wdata = store_data;
  end

  // little endian lane pick from the address offset
  assign byte_lane = rdata[{addr_low, 3'b000} +: 8];
  assign half_lane = rdata[{addr_low[1], 4'b0000} +: 16];

  always_comb begin
    case (load_type)
      rv32_exec_pkg::lt_lb:  load_data = {{24{byte_lane[7]}}, byte_lane};
      rv32_exec_pkg::lt_lbu: load_data = {24'b0, byte_lane};
      rv32_exec_pkg::lt_lh:  load_data = {{16{half_lane[15]}}, half_lane};
      rv32_exec_pkg::lt_lhu: load_data = {16'b0, half_lane};
      default:               load_data = rdata;
    endcase
  end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                 CLK,
  input  logic                 rst,
  input  rv32_exec_pkg::word_t instr,
  input  rv32_exec_pkg::word_t pc,
  input  logic                 prediction,
  input  logic                 stall,
  output rv32_exec_pkg::word_t brj_addr,
  output logic                 mispredict,
  output logic                 jump,
  output logic                 branch,
  output logic                 halt,
  output logic                 illegal_insn,
  output logic                 mal_l,
  output logic                 mal_s,
  output rv32_exec_pkg::word_t badaddr,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output rv32_exec_pkg::word_t dmem_addr,
  output rv32_exec_pkg::word_t dmem_wdata,
  output logic [3:0]           dmem_byte_en,
  input  rv32_exec_pkg::word_t dmem_rdata
);

  // decode outputs
  rv32_exec_pkg::reg_addr_t    rs1;
  rv32_exec_pkg::reg_addr_t    rs2;
  rv32_exec_pkg::reg_addr_t    rd;
  rv32_exec_pkg::word_t        imm_i;
  rv32_exec_pkg::word_t        imm_s;
  rv32_exec_pkg::word_t        imm_sb;
  rv32_exec_pkg::word_t        imm_uj;
  rv32_exec_pkg::word_t        imm_u;
  rv32_exec_pkg::alu_op_e      alu_op;
  rv32_exec_pkg::alu_a_sel_e   alu_a_sel;
  rv32_exec_pkg::alu_b_sel_e   alu_b_sel;
  rv32_exec_pkg::w_sel_e       w_sel;
  rv32_exec_pkg::load_type_e   load_type;
  rv32_exec_pkg::branch_type_e branch_type;
  logic                        reg_wen;
  logic                        dren;
  logic                        dwen;
  logic                        j_sel;

  // datapath
  rv32_exec_pkg::word_t rs1_data;
  rv32_exec_pkg::word_t rs2_data;
  rv32_exec_pkg::word_t w_data;
  rv32_exec_pkg::word_t port_a;
  rv32_exec_pkg::word_t port_b;
  rv32_exec_pkg::word_t alu_out;
  rv32_exec_pkg::word_t load_data;
  rv32_exec_pkg::word_t branch_addr;
  rv32_exec_pkg::word_t pc4;
  rv32_exec_pkg::word_t jump_sum;
  rv32_exec_pkg::word_t jump_addr;
  logic                 branch_taken;
  logic                 mal_addr;
  logic                 rf_wen;

  control_unit cu (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd),
    .imm_i(imm_i), .imm_s(imm_s), .imm_sb(imm_sb), .imm_uj(imm_uj), .imm_u(imm_u),
    .alu_op(alu_op), .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel), .w_sel(w_sel),
    .reg_wen(reg_wen), .dren(dren), .dwen(dwen), .load_type(load_type),
    .branch(branch), .branch_type(branch_type), .jump(jump), .j_sel(j_sel),
    .halt(halt), .illegal_insn(illegal_insn)
  );

  rv32i_reg_file rf (
    .CLK(CLK), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .wen(rf_wen), .w_data(w_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  // operand a is rs1, or pc for auipc
  assign port_a = (alu_a_sel == rv32_exec_pkg::a_sel_pc) ? pc : rs1_data;

  always_comb begin
    case (alu_b_sel)
      rv32_exec_pkg::b_sel_imm_i: port_b = imm_i;
      rv32_exec_pkg::b_sel_imm_s: port_b = imm_s;
      rv32_exec_pkg::b_sel_imm_u: port_b = imm_u;
      default:                    port_b = rs2_data;
    endcase
  end

  alu alu_inst (.aluop(alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

  branch_res br (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(pc), .imm_sb(imm_sb),
    .branch_type(branch_type), .branch_taken(branch_taken), .branch_addr(branch_addr)
  );

  dmem_align dmem (
    .load_type(load_type), .dren(dren), .dwen(dwen), .addr_low(alu_out[1:0]),
    .store_data(rs2_data), .rdata(dmem_rdata), .byte_en(dmem_byte_en),
    .mal_addr(mal_addr), .wdata(dmem_wdata), .load_data(load_data)
  );

  assign pc4 = pc + 32'd4;

  // one adder for both jumps, jal is pc relative and jalr rs1 relative
  assign jump_sum  = (j_sel ? pc : rs1_data) + (j_sel ? imm_uj : imm_i);
  assign jump_addr = {jump_sum[31:1], 1'b0};

  // jumps win, then a taken branch, else fall through
  always_comb begin
    if (jump)
      brj_addr = jump_addr;
    else if (branch && branch_taken)
      brj_addr = branch_addr;
    else
      brj_addr = pc4;
  end

  // only real branches can be mispredicted
  assign mispredict = branch & (prediction ^ branch_taken);

  always_comb begin
    case (w_sel)
      rv32_exec_pkg::w_sel_load:  w_data = load_data;
      rv32_exec_pkg::w_sel_pc4:   w_data = pc4;
      rv32_exec_pkg::w_sel_imm_u: w_data = imm_u;
      default:                    w_data = alu_out;
    endcase
  end

  // no write under stall or for a misaligned load
  assign rf_wen = reg_wen & ~stall & ~(dren & mal_addr);

  // alu result is the effective address
  assign dmem_addr = alu_out;
  assign dmem_ren  = dren & ~mal_addr;
  assign dmem_wen  = dwen & ~mal_addr;

  assign mal_l   = dren & mal_addr;
  assign mal_s   = dwen & mal_addr;
  assign badaddr = alu_out;

endmodule

// File: verif/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb;

  logic                 clk;
  logic                 rst;
  rv32_exec_pkg::word_t instr;
  rv32_exec_pkg::word_t pc;
  logic                 prediction;
  logic                 stall;
  rv32_exec_pkg::word_t brj_addr;
  logic                 mispredict;
  logic                 jump;
  logic                 branch;
  logic                 halt;
  logic                 illegal_insn;
  logic                 mal_l;
  logic                 mal_s;
  rv32_exec_pkg::word_t badaddr;
  logic                 dmem_ren;
  logic                 dmem_wen;
  rv32_exec_pkg::word_t dmem_addr;
  rv32_exec_pkg::word_t dmem_wdata;
  logic [3:0]           dmem_byte_en;
  rv32_exec_pkg::word_t dmem_rdata;

  // reference register state updated from the ISA rules
  rv32_exec_pkg::word_t ref_regs [0:31];
  // 256 byte data memory where the address wraps
  logic [7:0]           mem [0:255];
  integer               errors;
  integer               checks;
  integer               seed;

  execute_stage execute_stage_inst (
    .CLK(clk), .rst(rst), .instr(instr), .pc(pc), .prediction(prediction), .stall(stall),
    .brj_addr(brj_addr), .mispredict(mispredict), .jump(jump), .branch(branch),
    .halt(halt), .illegal_insn(illegal_insn), .mal_l(mal_l), .mal_s(mal_s),
    .badaddr(badaddr), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_byte_en(dmem_byte_en), .dmem_rdata(dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // little endian read data answers in the same cycle
  assign dmem_rdata = {mem[{dmem_addr[7:2], 2'b11}], mem[{dmem_addr[7:2], 2'b10}],
                       mem[{dmem_addr[7:2], 2'b01}], mem[{dmem_addr[7:2], 2'b00}]};

  // stores land at the edge that ends the cycle
  always @(posedge clk) begin
    if (dmem_wen) begin
      for (int k = 0; k < 4; k++)
        if (dmem_byte_en[k])
          mem[{dmem_addr[7:2], 2'(k)}] <= dmem_wdata[8*k +: 8];
    end
  end

  // instruction assemblers
  function automatic rv32_exec_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv32_exec_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv32_exec_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv32_exec_pkg::word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv32_exec_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv32_exec_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // expected result of an OP group instruction
  function automatic rv32_exec_pkg::word_t op_result(input logic [2:0] f3, input logic alt,
                                                    input rv32_exec_pkg::word_t a,
                                                    input rv32_exec_pkg::word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? rv32_exec_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_val(input string name, input rv32_exec_pkg::word_t exp,
                           input rv32_exec_pkg::word_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic write_ref(input logic [4:0] r, input rv32_exec_pkg::word_t v);
    // x0 is hardwired
    if (r != 5'd0)
      ref_regs[r] = v;
  endtask

  // drive on the rising edge and look at the outputs mid cycle
  task automatic issue(input rv32_exec_pkg::word_t i, input rv32_exec_pkg::word_t p,
                       input logic pred, input logic st);
    @(posedge clk);
    instr      <= i;
    pc         <= p;
    prediction <= pred;
    stall      <= st;
    @(negedge clk);
  endtask

  task automatic run(input rv32_exec_pkg::word_t i);
    issue(i, 32'h100, 1'b0, 1'b0);
  endtask

  // lui then addi where the addi immediate is sign extended
  task automatic set_reg(input logic [4:0] r, input rv32_exec_pkg::word_t v);
    rv32_exec_pkg::word_t hi;
    hi = v + 32'h800;
    run(u_type(hi[31:12], r, rv32_exec_pkg::op_lui));
    write_ref(r, {hi[31:12], 12'b0});
    run(i_type(v[11:0], r, 3'b000, r, rv32_exec_pkg::op_imm));
    write_ref(r, ref_regs[r] + {{20{v[11]}}, v[11:0]});
  endtask

  // sw to the scratch word shows the register on dmem_wdata
  task automatic read_reg(input logic [4:0] r);
    run(s_type(12'h080, r, 5'd0, 3'b010));
    check_val("dmem_wen", 1, dmem_wen);
    check_val($sformatf("dmem_wdata(x%0d)", r), ref_regs[r], dmem_wdata);
  endtask

  task automatic check_quiet();
    check_val("dmem_ren", 0, dmem_ren);
    check_val("dmem_wen", 0, dmem_wen);
    check_val("dmem_byte_en", 0, dmem_byte_en);
    check_val("halt", 0, halt);
    check_val("jump", 0, jump);
    check_val("branch", 0, branch);
    check_val("illegal_insn", 0, illegal_insn);
    check_val("mal_l", 0, mal_l);
    check_val("mal_s", 0, mal_s);
    check_val("mispredict", 0, mispredict);
  endtask

  task automatic reset_and_bubbles();
    @(negedge clk);
    check_quiet();
    for (int r = 0; r < 32; r++)
      read_reg(r[4:0]);
  endtask

  task automatic alu_writeback();
    rv32_exec_pkg::word_t a;
    rv32_exec_pkg::word_t b;
    rv32_exec_pkg::word_t imm;
    logic [2:0]           f3;
    logic                 alt;
    for (int n = 0; n < 4; n++) begin
      a = $random(seed);
      b = $random(seed);
      set_reg(5'd1, a);
      set_reg(5'd2, b);
      // k 8 and 9 are sub and sra
      for (int k = 0; k < 10; k++) begin
        alt = (k >= 8);
        f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'b000 : 3'b101);
        run(r_type(alt ? 7'b0100000 : 7'b0000000, 5'd2, 5'd1, f3, 5'd3));
        write_ref(5'd3, op_result(f3, alt, a, b));
        read_reg(5'd3);
      end
      imm = $random(seed);
      run(i_type(imm[11:0], 5'd1, 3'b000, 5'd4, rv32_exec_pkg::op_imm));
      write_ref(5'd4, a + {{20{imm[11]}}, imm[11:0]});
      read_reg(5'd4);
      run(u_type(imm[31:12], 5'd5, rv32_exec_pkg::op_lui));
      write_ref(5'd5, {imm[31:12], 12'b0});
      read_reg(5'd5);
      issue(u_type(imm[31:12], 5'd6, rv32_exec_pkg::op_auipc), {b[31:2], 2'b00}, 1'b0, 1'b0);
      write_ref(5'd6, {b[31:2], 2'b00} + {imm[31:12], 12'b0});
      read_reg(5'd6);
    end
    // x0 ignores the write
    run(i_type(12'h055, 5'd1, 3'b000, 5'd0, rv32_exec_pkg::op_imm));
    read_reg(5'd0);
  endtask

  task automatic loads_and_stores();
    rv32_exec_pkg::word_t v;
    logic [7:0]           b8;
    logic [15:0]          h16;
    v = $random(seed);
    set_reg(5'd5, v);
    for (int off = 0; off < 4; off++) begin
      run(s_type(12'h060 + 12'(off), 5'd5, 5'd0, 3'b000));
      check_val("dmem_addr", 32'h60 + 32'(off), dmem_addr);
      check_val("dmem_byte_en", 4'b0001 << off, dmem_byte_en);
      check_val("dmem_wdata", {4{v[7:0]}}, dmem_wdata);
    end
    for (int off = 0; off < 4; off += 2) begin
      run(s_type(12'h060 + 12'(off), 5'd5, 5'd0, 3'b001));
      check_val("dmem_byte_en", 4'b0011 << off, dmem_byte_en);
      check_val("dmem_wdata", {2{v[15:0]}}, dmem_wdata);
    end
    run(s_type(12'h060, 5'd5, 5'd0, 3'b010));
    check_val("dmem_byte_en", 4'hf, dmem_byte_en);
    check_val("dmem_wdata", v, dmem_wdata);
    // negative byte and half in the low lanes
    mem[8'h40] = 8'h81;
    mem[8'h41] = 8'hf2;
    mem[8'h42] = 8'h37;
    mem[8'h43] = 8'hc4;
    for (int off = 0; off < 4; off++) begin
      b8 = mem[8'h40 + off];
      run(i_type(12'h040 + 12'(off), 5'd0, 3'b000, 5'd6, rv32_exec_pkg::op_load));
      write_ref(5'd6, {{24{b8[7]}}, b8});
      read_reg(5'd6);
      run(i_type(12'h040 + 12'(off), 5'd0, 3'b100, 5'd6, rv32_exec_pkg::op_load));
      write_ref(5'd6, {24'b0, b8});
      read_reg(5'd6);
    end
    for (int off = 0; off < 4; off += 2) begin
      h16 = {mem[8'h41 + off], mem[8'h40 + off]};
      run(i_type(12'h040 + 12'(off), 5'd0, 3'b001, 5'd6, rv32_exec_pkg::op_load));
      write_ref(5'd6, {{16{h16[15]}}, h16});
      read_reg(5'd6);
      run(i_type(12'h040 + 12'(off), 5'd0, 3'b101, 5'd6, rv32_exec_pkg::op_load));
      write_ref(5'd6, {16'b0, h16});
      read_reg(5'd6);
    end
    run(i_type(12'h040, 5'd0, 3'b010, 5'd6, rv32_exec_pkg::op_load));
    check_val("dmem_ren", 1, dmem_ren);
    check_val("dmem_byte_en", 4'hf, dmem_byte_en);
    write_ref(5'd6, {mem[8'h43], mem[8'h42], mem[8'h41], mem[8'h40]});
    read_reg(5'd6);
  endtask

  // load into x7 then store from x7 at the same bad address
  task automatic misaligned_pair(input logic [2:0] f3, input logic [11:0] off);
    rv32_exec_pkg::word_t addr;
    addr = 32'h40 + off;
    run(i_type(addr[11:0], 5'd0, f3, 5'd7, rv32_exec_pkg::op_load));
    check_val("mal_l", 1, mal_l);
    check_val("mal_s", 0, mal_s);
    check_val("badaddr", addr, badaddr);
    check_val("dmem_ren", 0, dmem_ren);
    check_val("dmem_byte_en", 0, dmem_byte_en);
    run(s_type(addr[11:0], 5'd7, 5'd0, f3));
    check_val("mal_s", 1, mal_s);
    check_val("mal_l", 0, mal_l);
    check_val("badaddr", addr, badaddr);
    check_val("dmem_wen", 0, dmem_wen);
    check_val("dmem_byte_en", 0, dmem_byte_en);
  endtask

  task automatic misaligned_access();
    set_reg(5'd7, 32'hdeadbeef);
    for (int off = 1; off < 4; off++)
      misaligned_pair(3'b010, 12'(off));
    misaligned_pair(3'b001, 12'h001);
    misaligned_pair(3'b001, 12'h003);
    // the faulting loads must not have touched x7
    read_reg(5'd7);
  endtask

  task automatic control_flow();
    rv32_exec_pkg::word_t a;
    rv32_exec_pkg::word_t b;
    rv32_exec_pkg::word_t imm;
    rv32_exec_pkg::word_t p;
    logic                 taken;
    logic                 pred;
    logic [2:0]           f3;
    // operand pairs give both outcomes for every condition
    for (int pr = 0; pr < 3; pr++) begin
      a = (pr == 0) ? 32'hfffffffd : 32'd7;
      b = (pr == 2) ? 32'hfffffffd : 32'd7;
      set_reg(5'd8, a);
      set_reg(5'd9, b);
      for (int k = 0; k < 6; k++) begin
        f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        imm  = k[0] ? 32'hffffffe8 : 32'h00000040;
        p    = 32'h1000 + 32'(k * 16);
        pred = 1'($random(seed));
        issue(b_type(imm[12:0], 5'd9, 5'd8, f3), p, pred, 1'b0);
        check_val("branch", 1, branch);
        check_val("brj_addr", taken ? p + imm : p + 32'd4, brj_addr);
        check_val("mispredict", pred ^ taken, mispredict);
      end
    end
    // forward jal is never a mispredict
    issue(j_type(21'h0007f0, 5'd10), 32'h2000, 1'b0, 1'b0);
    check_val("jump", 1, jump);
    check_val("brj_addr", 32'h27f0, brj_addr);
    check_val("mispredict", 0, mispredict);
    write_ref(5'd10, 32'h2004);
    read_reg(5'd10);
    // jal backward by 0x100
    issue(j_type(21'h1fff00, 5'd10), 32'h2400, 1'b0, 1'b0);
    check_val("brj_addr", 32'h2300, brj_addr);
    write_ref(5'd10, 32'h2404);
    read_reg(5'd10);
    // jalr clears bit 0 of the sum
    set_reg(5'd12, 32'h3001);
    issue(i_type(12'h044, 5'd12, 3'b000, 5'd11, rv32_exec_pkg::op_jalr), 32'h2800, 1'b0, 1'b0);
    check_val("jump", 1, jump);
    check_val("brj_addr", 32'h3044, brj_addr);
    write_ref(5'd11, 32'h2804);
    read_reg(5'd11);
  endtask

  task automatic stall_halt_illegal();
    set_reg(5'd13, 32'h0badcafe);
    // addi held for two cycles with stall high
    issue(i_type(12'h123, 5'd0, 3'b000, 5'd13, rv32_exec_pkg::op_imm), 32'h100, 1'b0, 1'b1);
    issue(i_type(12'h123, 5'd0, 3'b000, 5'd13, rv32_exec_pkg::op_imm), 32'h100, 1'b0, 1'b1);
    read_reg(5'd13);
    // ecall then ebreak
    run(32'h00000073);
    check_val("halt", 1, halt);
    check_val("illegal_insn", 0, illegal_insn);
    run(32'h00100073);
    check_val("halt", 1, halt);
    // opcode 1111111 is not in the base set
    run(32'h0000107f);
    check_val("illegal_insn", 1, illegal_insn);
    check_val("halt", 0, halt);
    // store funct3 100 has no encoding so no write may leave
    run(s_type(12'h060, 5'd5, 5'd0, 3'b100));
    check_val("illegal_insn", 1, illegal_insn);
    check_val("dmem_wen", 0, dmem_wen);
  endtask

  initial begin
    seed       = 32'h4920;
    errors     = 0;
    checks     = 0;
    rst        = 1'b1;
    instr      = '0;
    pc         = '0;
    prediction = 1'b0;
    stall      = 1'b0;
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    // odd multiplier keeps every byte address distinct
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 37 + 11);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    reset_and_bubbles();
    alu_writeback();
    loads_and_stores();
    misaligned_access();
    control_flow();
    stall_halt_illegal();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog on the whole sequence
  initial begin
    for (int n = 0; n < 4000; n++)
      @(posedge clk);
    $display("timeout: the test sequence did not finish within 4000 cycles");
    $display("Test failed");
    $finish;
  end

endmodule

// File: rv32_exec.f
hw/rv32_exec_pkg.sv
hw/control_unit.sv
hw/rv32i_reg_file.sv
hw/alu.sv
hw/branch_res.sv
hw/dmem_align.sv
hw/execute_stage.sv
verif/execute_stage_tb.sv

// File: Bender.yml
package:
  name: rv32_exec

sources:
  - hw/rv32_exec_pkg.sv
  - hw/control_unit.sv
  - hw/rv32i_reg_file.sv
  - hw/alu.sv
  - hw/branch_res.sv
  - hw/dmem_align.sv
  - hw/execute_stage.sv
  - target: simulation
    files:
      - verif/execute_stage_tb.sv
